// File: lenet_pkg.sv
`default_nettype none

package lenet_pkg;

    // -------------------------------------------------------------------------
    // Datapath widths
    // -------------------------------------------------------------------------
    localparam int PIX_W  = 8;   // Pixel and weight
    localparam int PROD_W = 16;  // Approximate product
    localparam int ACC_W  = 24;  // Up to 256 full-scale beats per lane
    localparam int ACT_W  = 8;   // Saturated activation

    // -------------------------------------------------------------------------
    // Beat, control and result words
    // -------------------------------------------------------------------------

    // One operand pair per lane and beat
    typedef struct packed {
        logic [PIX_W-1:0] pixel;
        logic [PIX_W-1:0] weight;
    } pair_t;

    // Per-beat strobes shared by all lanes
    typedef struct packed {
        logic valid;  // Beat present
        logic first;  // Load instead of accumulate
        logic last;   // Window closes with this beat
    } lane_ctl_t;

    typedef struct packed {
        logic [ACC_W-1:0] sum;
        logic [ACT_W-1:0] act;
    } conv_result_t;

endpackage

`default_nettype wire

// File: approx_mul_8x8.sv
`default_nettype none

module approx_mul_8x8 import lenet_pkg::*; (
    input  logic [PIX_W-1:0]  a,
    input  logic [PIX_W-1:0]  b,
    output logic [PROD_W-1:0] p
);

    localparam int ROW_W = 13;  // Span of the compressed lower rows

    logic [PIX_W-1:0][PIX_W-1:0] pp;  // pp[i] is b gated by a[i]
    logic [PROD_W-1:0]           upper;
    logic [ROW_W-1:0]            row1;
    logic [ROW_W-1:0]            row2;
    logic [ROW_W-1:0]            row3;
    logic                        w8_and;
    logic                        w8_or;

    always_comb begin
        for (int i = 0; i < PIX_W; i++) begin
            pp[i] = b & {PIX_W{a[i]}};
        end
    end

    // -------------------------------------------------------------------------
    // Exact part, rows 6 and 7 keep every bit
    // -------------------------------------------------------------------------
    assign upper = PROD_W'({pp[6], 6'b0}) + PROD_W'({pp[7], 7'b0});

    // -------------------------------------------------------------------------
    // Lower six rows, merged in pairs bit by bit
    // Columns listed from bit 12 down to bit 0
    // -------------------------------------------------------------------------
    assign row1 = {
        pp[4][7] & pp[5][6],   // 12
        pp[4][6] & pp[5][5],   // 11
        pp[2][7] & pp[3][6],   // 10, carry of the pair below
        pp[2][7] | pp[3][6],   // 9
        pp[1][7],              // 8
        pp[0][7] ^ pp[1][6],   // 7
        pp[2][3] & pp[3][2],   // 6
        1'b0,
        pp[2][1] ^ pp[3][0],   // 4
        1'b0,
        pp[0][1] ^ pp[1][0],   // 2
        2'b00                  // Bits 1 and 0 dropped
    };

    assign row2 = {
        pp[5][7],              // 12
        pp[4][7] ^ pp[5][6],   // 11
        pp[3][7],              // 10
        pp[4][5] & pp[5][4],   // 9
        pp[2][5] | pp[3][4],   // 8
        pp[4][2] | pp[5][1],   // 7
        pp[2][4] | pp[3][3],   // 6
        1'b0,
        pp[4][0],              // 4
        4'b0000
    };

    assign row3 = {
        2'b00,
        pp[4][6] ^ pp[5][5],   // 10
        pp[4][5] | pp[5][4],   // 9
        pp[2][6] | pp[3][5],   // 8
        pp[4][3] ^ pp[5][2],   // 7
        pp[4][2] & pp[5][1],   // 6
        6'b000000
    };

    // Weight 8 pair kept as two separate terms
    assign w8_and = pp[4][4] & pp[5][3];
    assign w8_or  = pp[4][4] | pp[5][3];

    // Most low-order columns are gone, so the result leans low
    assign p = upper
             + PROD_W'(row1)
             + PROD_W'(row2)
             + PROD_W'(row3)
             + PROD_W'({w8_and, 8'b0})
             + PROD_W'({w8_or, 8'b0});

endmodule

`default_nettype wire

// File: mac_lane.sv
`default_nettype none

module mac_lane import lenet_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  pair_t            pair,
    input  lane_ctl_t        ctl,
    output logic [ACC_W-1:0] acc,
    output lane_ctl_t        acc_ctl
);

    logic [PROD_W-1:0] prod;
    logic [ACC_W-1:0]  prod_ext;

    approx_mul_8x8 mul_i (
        .a (pair.pixel),
        .b (pair.weight),
        .p (prod)
    );

    assign prod_ext = ACC_W'(prod);

    // -------------------------------------------------------------------------
    // Accumulator and its control word move together
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc     <= '0;
            acc_ctl <= '0;
        end else begin
            acc_ctl <= ctl;  // Tells the reducer what acc now holds
            if (ctl.valid) begin
                if (ctl.first) begin
                    acc <= prod_ext;  // New window
                end else begin
                    acc <= acc + prod_ext;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: window_feeder.sv
`default_nettype none

module window_feeder import lenet_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic                  start,
    input  logic                  in_last,
    input  pair_t [NUM_LANES-1:0] in_pairs,
    output pair_t [NUM_LANES-1:0] lane_pairs,
    output lane_ctl_t             lane_ctl
);

    logic start_pend;  // Start seen, no beat yet
    logic open_win;

    // Start may arrive with the opening beat or any cycle before it
    assign open_win = start | start_pend;

    // -------------------------------------------------------------------------
    // Window tracking and control stage
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_pend <= 1'b0;
            lane_ctl   <= '0;
        end else begin
            if (in_valid) begin
                start_pend <= 1'b0;  // Consumed by this beat
            end else if (start) begin
                start_pend <= 1'b1;
            end

            lane_ctl.valid <= in_valid;
            lane_ctl.first <= in_valid & open_win;
            lane_ctl.last  <= in_valid & in_last;
        end
    end

    // Pairs hold their value through gaps
    always_ff @(posedge clk) begin
        if (in_valid) begin
            lane_pairs <= in_pairs;
        end
    end

endmodule

`default_nettype wire

// File: lane_reducer.sv
`default_nettype none

module lane_reducer import lenet_pkg::*; #(
    parameter int NUM_LANES = 4,
    parameter int OUT_SHIFT = 6
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_LANES-1:0][ACC_W-1:0]  lane_acc,
    input  lane_ctl_t                        acc_ctl,
    output logic                             out_valid,
    output conv_result_t                     out_result
);

    logic [ACC_W-1:0] sum;
    logic [ACC_W-1:0] shifted;
    logic [ACT_W-1:0] act;
    logic             fire;

    // -------------------------------------------------------------------------
    // Lane sum and activation
    // -------------------------------------------------------------------------
    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            sum = sum + lane_acc[i];
        end
    end

    assign shifted = sum >> OUT_SHIFT;

    // Clamp to full scale when any bit above the activation is set
    assign act = (|shifted[ACC_W-1:ACT_W]) ? '1 : shifted[ACT_W-1:0];

    assign fire = acc_ctl.valid & acc_ctl.last;  // Accumulators hold a full window

    // -------------------------------------------------------------------------
    // Output register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fire;  // Single-cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_result.sum <= sum;
            out_result.act <= act;
        end
    end

endmodule

`default_nettype wire

// File: conv_dot_top.sv
`default_nettype none

module conv_dot_top import lenet_pkg::*; #(
    parameter int NUM_LANES = 4,
    parameter int OUT_SHIFT = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic                  start,
    input  logic                  in_last,
    input  pair_t [NUM_LANES-1:0] in_pairs,
    output logic                  out_valid,
    output conv_result_t          out_result
);

    pair_t [NUM_LANES-1:0]            lane_pairs;
    lane_ctl_t                        lane_ctl;
    logic [NUM_LANES-1:0][ACC_W-1:0]  lane_acc;
    lane_ctl_t                        acc_ctl;

    window_feeder #(
        .NUM_LANES (NUM_LANES)
    ) feeder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .start      (start),
        .in_last    (in_last),
        .in_pairs   (in_pairs),
        .lane_pairs (lane_pairs),
        .lane_ctl   (lane_ctl)
    );

    // Lane 0 alone carries the delayed control to the reducer
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        if (i == 0) begin : g_head
            mac_lane lane_i (
                .clk     (clk),
                .rst_n   (rst_n),
                .pair    (lane_pairs[i]),
                .ctl     (lane_ctl),
                .acc     (lane_acc[i]),
                .acc_ctl (acc_ctl)
            );
        end else begin : g_tail
            mac_lane lane_i (
                .clk     (clk),
                .rst_n   (rst_n),
                .pair    (lane_pairs[i]),
                .ctl     (lane_ctl),
                .acc     (lane_acc[i]),
                .acc_ctl ()
            );
        end
    end

    lane_reducer #(
        .NUM_LANES (NUM_LANES),
        .OUT_SHIFT (OUT_SHIFT)
    ) reducer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_acc   (lane_acc),
        .acc_ctl    (acc_ctl),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

// File: conv_dot_checker.sv
`default_nettype none

module conv_dot_checker (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_last,
    input logic out_valid
);

    // ------------------------------------------------------------------------
    // Reset behavior
    // ------------------------------------------------------------------------
    assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    assert property (@(posedge clk) $rose(rst_n) |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // ------------------------------------------------------------------------
    // Strobe shape and latency
    // ------------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
        else $error("out_valid high two cycles in a row");

    // Sampled one edge after the output register loads
    assert property (@(posedge clk) disable iff (!rst_n)
                     (in_valid && in_last) |-> ##3 out_valid)
        else $error("out_valid missing 3 cycles after a last beat");

endmodule

bind conv_dot_top conv_dot_checker checker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .out_valid (out_valid)
);

`default_nettype wire

// File: conv_dot_tb.sv
`default_nettype none

module conv_dot_tb import lenet_pkg::*; ();

    localparam int NUM_LANES      = 4;
    localparam int MEM_DEPTH      = 512;
    localparam int RESULT_TIMEOUT = 20;  // Cycles from a last beat
    localparam int LATENCY        = 3;   // Drive cycle to out_valid cycle
    localparam int WATCHDOG       = 3000;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  start;
    logic                  in_last;
    pair_t [NUM_LANES-1:0] in_pairs;
    logic                  out_valid;
    conv_result_t          out_result;

    logic [31:0]  cases_mem [MEM_DEPTH];
    logic [31:0]  lfsr_state;
    int           cycle_cnt = 0;
    int           error_count = 0;
    int           timeout_count = 0;
    conv_result_t exp_res_q[$];
    int           exp_due_q[$];

    conv_dot_top conv_dot_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .start      (start),
        .in_last    (in_last),
        .in_pairs   (in_pairs),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ------------------------------------------------------------------------
    // Random source and compare tasks
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // Taps 32, 22, 2, 1
        return {s[30:0], fb};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    task automatic check_result(input conv_result_t got, input conv_result_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: sum %0h act %0h, expected sum %0h act %0h",
                     $time, got.sum, got.act, exp.sum, exp.act);
        end
    endtask

    task automatic check_idle(input logic seen);
        if (seen !== 1'b0) begin
            error_count++;
            $display("Unexpected out_valid at time %0t with no window pending", $time);
        end
    endtask

    // Gap cycle with junk on the data inputs
    task automatic drive_idle(input logic start_now);
        in_valid = 1'b0;
        start    = start_now;
        in_last  = 1'(rand_bits(1));
        for (int i = 0; i < NUM_LANES; i++) begin
            in_pairs[i] = 16'(rand_bits(16));
        end
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------------------
    // Stimulus from the case file
    // ------------------------------------------------------------------------
    initial begin
        int          ptr;
        int          gap;
        int          tag;
        int          last_due;
        int          wait_cnt;
        logic [31:0] smode;
        logic        done;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        start      = 1'b0;
        in_last    = 1'b0;
        in_pairs   = '0;
        lfsr_state = 32'h96fb;
        last_due   = 0;
        $readmemh("conv_cases.txt", cases_mem);
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        ptr   = 0;
        done  = 1'b0;
        while (!done) begin
            tag = int'(cases_mem[ptr]);
            case (tag)
                1: begin  // Beat
                    gap   = int'(cases_mem[ptr+1]);
                    smode = cases_mem[ptr+2];
                    if (gap == 'hff) gap = rand_bits(2);
                    if (smode == 2 && gap == 0) gap = 1;  // Early start needs a gap
                    for (int g = 0; g < gap; g++) begin
                        drive_idle(smode == 2 && g == gap - 1);
                    end
                    in_valid = 1'b1;
                    start    = (smode == 1);
                    in_last  = cases_mem[ptr+3][0];
                    for (int i = 0; i < NUM_LANES; i++) begin
                        in_pairs[i] = cases_mem[ptr+4+i][15:0];
                    end
                    if (in_last) last_due = cycle_cnt + LATENCY;
                    @(posedge clk);
                    #1;
                    ptr += 4 + NUM_LANES;
                end
                2: begin  // Expected result of the window just sent
                    exp_res_q.push_back({cases_mem[ptr+1][ACC_W-1:0],
                                         cases_mem[ptr+2][ACT_W-1:0]});
                    exp_due_q.push_back(last_due);
                    ptr += 3;
                end
                3: begin
                    repeat (int'(cases_mem[ptr+1])) drive_idle(1'b0);
                    ptr += 2;
                end
                0: done = 1'b1;
                default: begin
                    error_count++;
                    $display("Unknown record in the case file at word %0d", ptr);
                    done = 1'b1;
                end
            endcase
        end

        wait_cnt = 0;
        while (exp_res_q.size() != 0 && wait_cnt < 2 * RESULT_TIMEOUT) begin
            drive_idle(1'b0);
            wait_cnt++;
        end
        if (exp_res_q.size() != 0) begin
            timeout_count++;
            $display("Results still missing at the end of the run");
        end
        repeat (5) drive_idle(1'b0);

        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // ------------------------------------------------------------------------
    // Output monitor sampled at the falling edge
    // ------------------------------------------------------------------------
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n !== 1'b1) begin
                check_idle(out_valid);
            end else if (out_valid === 1'b1 && exp_res_q.size() != 0) begin
                if (cycle_cnt != exp_due_q[0]) begin
                    error_count++;
                    $display("Error at %0t: result in cycle %0d, expected cycle %0d",
                             $time, cycle_cnt, exp_due_q[0]);
                end
                check_result(out_result, exp_res_q[0]);
                void'(exp_res_q.pop_front());
                void'(exp_due_q.pop_front());
            end else if (exp_res_q.size() != 0) begin
                if (cycle_cnt >= exp_due_q[0] - LATENCY + RESULT_TIMEOUT) begin
                    timeout_count++;
                    $display("No result within %0d cycles of its last beat", RESULT_TIMEOUT);
                    void'(exp_res_q.pop_front());
                    void'(exp_due_q.pop_front());
                end
            end else begin
                check_idle(out_valid);
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Simulation stopped after %0d cycles without finishing", WATCHDOG);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: conv_cases.txt
// Beat:   1 gap start last pair0 pair1 pair2 pair3  (pair = pixel weight, gap ff = random)
// Result: 2 sum act    Idle: 3 cycles    End: 0    (start 1 = with beat, 2 = cycle before)
// Single-beat windows with operands 0, 1 and 255
1 2 1 1 0000 0101 ffff ff01
2 fc74 ff
1 3 1 1 01ff 0001 ff00 0101
2 84 2
1 2 1 1 ff01 ff01 ff01 ff01
2 390 e
// Multi-beat window with random gaps, start sent early
1 ff 2 0 4003 4003 4003 4003
1 ff 0 0 8002 8002 8002 8002
1 ff 0 0 0101 0101 0101 0101
1 ff 0 1 c001 c001 c001 c001
2 a00 28
// Back-to-back windows
1 0 1 0 4001 4001 4001 4001
1 0 0 1 01ff 01ff 01ff 01ff
2 310 c
1 0 1 0 ffff ffff ffff ffff
1 ff 0 0 ffff ffff ffff ffff
1 0 0 1 ffff ffff ffff ffff
2 bcac0 ff
// Idle stretch
3 1e
// Mixed lanes, then saturation just over full scale
1 2 1 0 8001 4002 c001 0101
1 ff 0 1 0000 01ff 0001 ff01
2 328 c
1 1 2 1 8080 0000 0000 0000
2 4000 ff
1 3 1 1 4001 0101 0000 0000
2 40 1
3 14
0

// File: build.f
lenet_pkg.sv
approx_mul_8x8.sv
mac_lane.sv
window_feeder.sv
lane_reducer.sv
conv_dot_top.sv
conv_dot_checker.sv
conv_dot_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module conv_dot_tb \
    -o conv_dot_sim > sim.log 2>&1 &&
    ./obj_dir/conv_dot_sim >> sim.log 2>&1 ||
    echo "TEST RESULT: FAIL" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
